//--- nes_glue_pkg.sv
package nes_glue_pkg;

  // controller serial ports
  localparam int joy_stream_w = 24;
  localparam int joy_buttons_w = 8;

  // signature bytes sent after the extra pad on each port
  localparam logic [7:0] multitap_sig_port1 = 8'h08;
  localparam logic [7:0] multitap_sig_port2 = 8'h04;

  // reset hold after a rom download
  localparam int download_cnt_w = 8;
  localparam logic [download_cnt_w-1:0] download_hold = 8'd255;

  // loader mapper flags word
  localparam int mapper_flags_w = 64;
  localparam int has_save_bit = 25;

  // mapper id field sits in flags bits 7..0
  localparam int mapper_id_w = 8;
  localparam logic [mapper_id_w-1:0] fds_mapper_id = 8'h14;

  // memory side widths
  localparam int data_w = 8;
  localparam int sdram_addr_w = 25;
  localparam int ppu_addr_w = 22;
  localparam int save_addr_w = 18;

  // backup ram lives in this sdram region
  localparam logic [sdram_addr_w-save_addr_w-1:0] save_region_prefix = 7'b0001111;

endpackage

//--- joypad_serializer.sv
`timescale 1ns/100ps

module joypad_serializer (
  input  logic                                    clk_ppu_21_47,
  input  logic                                    reset_nes,
  input  logic                                    multitap_enabled,
  input  logic                                    joy_strobe,
  input  logic [1:0]                              joy_clock,
  input  logic [nes_glue_pkg::joy_buttons_w-1:0]  p1_buttons,
  input  logic [nes_glue_pkg::joy_buttons_w-1:0]  p2_buttons,
  input  logic [nes_glue_pkg::joy_buttons_w-1:0]  p3_buttons,
  input  logic [nes_glue_pkg::joy_buttons_w-1:0]  p4_buttons,
  output logic                                    joy1_data,
  output logic                                    joy2_data
);

  localparam int upper_w = nes_glue_pkg::joy_stream_w - nes_glue_pkg::joy_buttons_w;

  // one stream per port, bit 0 is what the core reads
  logic [nes_glue_pkg::joy_stream_w-1:0] stream [2];
  logic [nes_glue_pkg::joy_stream_w-1:0] load_word [2];

  logic [1:0] joy_clock_q;
  logic [1:0] joy_fall;

  // upper part of each stream, extra pad plus signature or all ones
  logic [upper_w-1:0] upper_port1;
  logic [upper_w-1:0] upper_port2;

  assign upper_port1 = multitap_enabled ?
                       {nes_glue_pkg::multitap_sig_port1, p3_buttons} :
                       {upper_w{1'b1}};
  assign upper_port2 = multitap_enabled ?
                       {nes_glue_pkg::multitap_sig_port2, p4_buttons} :
                       {upper_w{1'b1}};

  assign load_word[0] = {upper_port1, p1_buttons};
  assign load_word[1] = {upper_port2, p2_buttons};

  // falling edge seen one cycle late, previous high and current low
  assign joy_fall = joy_clock_q & ~joy_clock;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      stream[0]   <= '0;
      stream[1]   <= '0;
      joy_clock_q <= '0;
    end else begin
      joy_clock_q <= joy_clock;
      for (int n = 0; n < 2; n++) begin
        // shift has priority over the strobe load
        if (joy_fall[n]) begin
          stream[n] <= {1'b0, stream[n][nes_glue_pkg::joy_stream_w-1:1]};
        end else if (joy_strobe) begin
          stream[n] <= load_word[n];
        end
      end
    end
  end

  assign joy1_data = stream[0][0];
  assign joy2_data = stream[1][0];

  // a shifted stream always takes a zero in at the top
  property p_shift_fills_zero(int n);
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
      joy_fall[n] |=> !stream[n][nes_glue_pkg::joy_stream_w-1];
  endproperty

  a_port1_shift_zero: assert property (p_shift_fills_zero(0))
    else $error("port 1 stream top bit not cleared after shift");

  a_port2_shift_zero: assert property (p_shift_fills_zero(1))
    else $error("port 2 stream top bit not cleared after shift");

endmodule

//--- load_control.sv
`timescale 1ns/100ps

module load_control (
  input  logic                                     clk_ppu_21_47,
  input  logic                                     reset_nes,
  input  logic                                     downloading,
  input  logic                                     loader_busy,
  input  logic                                     loader_done,
  input  logic                                     loader_fail,
  input  logic                                     hold_reset,
  input  logic [nes_glue_pkg::mapper_flags_w-1:0]  loader_flags,
  output logic                                     core_reset,
  output logic                                     loader_reset,
  output logic [nes_glue_pkg::mapper_flags_w-1:0]  core_mapper_flags,
  output logic                                     has_save,
  output logic                                     is_fds
);

  // set once the first download has started
  logic init_done;

  logic [nes_glue_pkg::download_cnt_w-1:0] hold_cnt;
  logic                                    hold_active;
  logic                                    downloading_q;
  logic                                    download_rise;

  logic [nes_glue_pkg::mapper_flags_w-1:0] mapper_flags;

  assign hold_active   = (hold_cnt != '0);
  assign download_rise = downloading && !downloading_q;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      init_done <= 1'b0;
    end else if (downloading) begin
      init_done <= 1'b1;
    end
  end

  // reload while downloading, then count down while the loader is idle
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      hold_cnt <= '0;
    end else if (downloading) begin
      hold_cnt <= nes_glue_pkg::download_hold;
    end else if (!loader_busy && hold_active) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // loader held in reset once the hold is over, and pulsed on download start
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      downloading_q <= 1'b0;
      loader_reset  <= 1'b1;
    end else begin
      downloading_q <= downloading;
      loader_reset  <= !hold_active || download_rise;
    end
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      mapper_flags <= '0;
    end else if (loader_done) begin
      mapper_flags <= loader_flags;
    end
  end

  assign core_reset = !init_done || hold_active || loader_fail || hold_reset || reset_nes;

  // core sees no mapper while a new image is coming in
  assign core_mapper_flags = downloading ? '0 : mapper_flags;

  assign has_save = mapper_flags[nes_glue_pkg::has_save_bit];
  assign is_fds   = (mapper_flags[nes_glue_pkg::mapper_id_w-1:0] == nes_glue_pkg::fds_mapper_id);

  a_hold_cnt_range: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
      hold_cnt <= nes_glue_pkg::download_hold
  ) else $error("download hold counter out of range");

endmodule

//--- sdram_channel_mux.sv
`timescale 1ns/100ps

module sdram_channel_mux (
  input  logic                                   clk_ppu_21_47,
  input  logic                                   downloading,
  input  logic                                   loader_busy,
  input  logic [nes_glue_pkg::sdram_addr_w-1:0]  loader_addr,
  input  logic [nes_glue_pkg::data_w-1:0]        loader_data,
  input  logic                                   loader_write,
  input  logic [nes_glue_pkg::ppu_addr_w-1:0]    ppu_addr,
  input  logic [nes_glue_pkg::data_w-1:0]        ppu_dout,
  input  logic                                   ppu_read,
  input  logic                                   ppu_write,
  input  logic                                   save_sleep,
  input  logic [nes_glue_pkg::sdram_addr_w-1:0]  ss_sdram_addr,
  input  logic                                   ss_sdram_wr,
  input  logic                                   ss_sdram_rd,
  input  logic [nes_glue_pkg::data_w-1:0]        ss_sdram_wdata,
  input  logic [nes_glue_pkg::save_addr_w-1:0]   sd_buff_addr,
  input  logic [nes_glue_pkg::data_w-1:0]        sd_buff_dout,
  input  logic                                   sd_buff_wr,
  input  logic                                   sd_buff_rd,
  input  logic                                   ch2_busy,
  input  logic [nes_glue_pkg::data_w-1:0]        ch2_dout,
  input  logic                                   bram_en,
  input  logic [nes_glue_pkg::data_w-1:0]        eeprom_dout,
  output logic [nes_glue_pkg::sdram_addr_w-1:0]  ch0_addr,
  output logic [nes_glue_pkg::data_w-1:0]        ch0_din,
  output logic                                   ch0_wr,
  output logic                                   ch0_rd,
  output logic [nes_glue_pkg::sdram_addr_w-1:0]  ch2_addr,
  output logic [nes_glue_pkg::data_w-1:0]        ch2_din,
  output logic                                   ch2_wr,
  output logic                                   ch2_rd,
  output logic [nes_glue_pkg::data_w-1:0]        sd_buff_din
);

  localparam int ppu_pad_w = nes_glue_pkg::sdram_addr_w - nes_glue_pkg::ppu_addr_w;

  // loader owns ch0 for the whole load
  logic loading;

  assign loading = downloading || loader_busy;

  assign ch0_addr = loading ? loader_addr : {{ppu_pad_w{1'b0}}, ppu_addr};
  assign ch0_din  = loading ? loader_data : ppu_dout;
  assign ch0_wr   = loader_write || ppu_write;
  assign ch0_rd   = ppu_read && !loading;

  // savestate engine takes ch2 while the core sleeps, backup buffer otherwise
  assign ch2_addr = save_sleep ? ss_sdram_addr :
                    {nes_glue_pkg::save_region_prefix, sd_buff_addr};
  assign ch2_din  = save_sleep ? ss_sdram_wdata : sd_buff_dout;
  assign ch2_wr   = save_sleep ? ss_sdram_wr : (sd_buff_wr && !ch2_busy);
  assign ch2_rd   = save_sleep ? ss_sdram_rd : (sd_buff_rd && !ch2_busy);

  assign sd_buff_din = bram_en ? eeprom_dout : ch2_dout;

  a_no_ppu_read_while_loading: assert property (
    @(posedge clk_ppu_21_47) loading |-> !ch0_rd
  ) else $error("ch0 read strobe high while loading");

endmodule

//--- nes_glue_top.sv
`timescale 1ns/100ps

module nes_glue_top (
  input  logic                                     clk_ppu_21_47,
  input  logic                                     reset_nes,
  // controllers
  input  logic                                     multitap_enabled,
  input  logic                                     joy_strobe,
  input  logic [1:0]                               joy_clock,
  input  logic [nes_glue_pkg::joy_buttons_w-1:0]   p1_buttons,
  input  logic [nes_glue_pkg::joy_buttons_w-1:0]   p2_buttons,
  input  logic [nes_glue_pkg::joy_buttons_w-1:0]   p3_buttons,
  input  logic [nes_glue_pkg::joy_buttons_w-1:0]   p4_buttons,
  output logic                                     joy1_data,
  output logic                                     joy2_data,
  // loader and reset
  input  logic                                     downloading,
  input  logic                                     loader_busy,
  input  logic                                     loader_done,
  input  logic                                     loader_fail,
  input  logic                                     hold_reset,
  input  logic [nes_glue_pkg::mapper_flags_w-1:0]  loader_flags,
  output logic                                     core_reset,
  output logic                                     loader_reset,
  output logic [nes_glue_pkg::mapper_flags_w-1:0]  core_mapper_flags,
  output logic                                     has_save,
  output logic                                     is_fds,
  // sdram request sources
  input  logic [nes_glue_pkg::sdram_addr_w-1:0]    loader_addr,
  input  logic [nes_glue_pkg::data_w-1:0]          loader_data,
  input  logic                                     loader_write,
  input  logic [nes_glue_pkg::ppu_addr_w-1:0]      ppu_addr,
  input  logic [nes_glue_pkg::data_w-1:0]          ppu_dout,
  input  logic                                     ppu_read,
  input  logic                                     ppu_write,
  input  logic                                     save_sleep,
  input  logic [nes_glue_pkg::sdram_addr_w-1:0]    ss_sdram_addr,
  input  logic                                     ss_sdram_wr,
  input  logic                                     ss_sdram_rd,
  input  logic [nes_glue_pkg::data_w-1:0]          ss_sdram_wdata,
  // backup buffer
  input  logic [nes_glue_pkg::save_addr_w-1:0]     sd_buff_addr,
  input  logic [nes_glue_pkg::data_w-1:0]          sd_buff_dout,
  input  logic                                     sd_buff_wr,
  input  logic                                     sd_buff_rd,
  input  logic                                     bram_en,
  input  logic [nes_glue_pkg::data_w-1:0]          eeprom_dout,
  output logic [nes_glue_pkg::data_w-1:0]          sd_buff_din,
  // sdram channels
  input  logic                                     ch2_busy,
  input  logic [nes_glue_pkg::data_w-1:0]          ch2_dout,
  output logic [nes_glue_pkg::sdram_addr_w-1:0]    ch0_addr,
  output logic [nes_glue_pkg::data_w-1:0]          ch0_din,
  output logic                                     ch0_wr,
  output logic                                     ch0_rd,
  output logic [nes_glue_pkg::sdram_addr_w-1:0]    ch2_addr,
  output logic [nes_glue_pkg::data_w-1:0]          ch2_din,
  output logic                                     ch2_wr,
  output logic                                     ch2_rd
);

  joypad_serializer u_joypad (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .multitap_enabled (multitap_enabled),
    .joy_strobe       (joy_strobe),
    .joy_clock        (joy_clock),
    .p1_buttons       (p1_buttons),
    .p2_buttons       (p2_buttons),
    .p3_buttons       (p3_buttons),
    .p4_buttons       (p4_buttons),
    .joy1_data        (joy1_data),
    .joy2_data        (joy2_data)
  );

  load_control u_load (
    .clk_ppu_21_47     (clk_ppu_21_47),
    .reset_nes         (reset_nes),
    .downloading       (downloading),
    .loader_busy       (loader_busy),
    .loader_done       (loader_done),
    .loader_fail       (loader_fail),
    .hold_reset        (hold_reset),
    .loader_flags      (loader_flags),
    .core_reset        (core_reset),
    .loader_reset      (loader_reset),
    .core_mapper_flags (core_mapper_flags),
    .has_save          (has_save),
    .is_fds            (is_fds)
  );

  // clock on the mux only feeds its checks
  sdram_channel_mux u_mux (
    .clk_ppu_21_47  (clk_ppu_21_47),
    .downloading    (downloading),
    .loader_busy    (loader_busy),
    .loader_addr    (loader_addr),
    .loader_data    (loader_data),
    .loader_write   (loader_write),
    .ppu_addr       (ppu_addr),
    .ppu_dout       (ppu_dout),
    .ppu_read       (ppu_read),
    .ppu_write      (ppu_write),
    .save_sleep     (save_sleep),
    .ss_sdram_addr  (ss_sdram_addr),
    .ss_sdram_wr    (ss_sdram_wr),
    .ss_sdram_rd    (ss_sdram_rd),
    .ss_sdram_wdata (ss_sdram_wdata),
    .sd_buff_addr   (sd_buff_addr),
    .sd_buff_dout   (sd_buff_dout),
    .sd_buff_wr     (sd_buff_wr),
    .sd_buff_rd     (sd_buff_rd),
    .ch2_busy       (ch2_busy),
    .ch2_dout       (ch2_dout),
    .bram_en        (bram_en),
    .eeprom_dout    (eeprom_dout),
    .ch0_addr       (ch0_addr),
    .ch0_din        (ch0_din),
    .ch0_wr         (ch0_wr),
    .ch0_rd         (ch0_rd),
    .ch2_addr       (ch2_addr),
    .ch2_din        (ch2_din),
    .ch2_wr         (ch2_wr),
    .ch2_rd         (ch2_rd),
    .sd_buff_din    (sd_buff_din)
  );

endmodule

//--- nes_glue_checker.sv
`timescale 1ns/100ps

module nes_glue_checker (
  input  logic        clk_ppu_21_47,
  input  logic        reset_nes,
  input  logic        chk_joy, chk_core_reset, chk_loader_reset, chk_flags, chk_mux,
  input  logic        joy1_data, joy2_data, exp_joy1, exp_joy2,
  input  logic        core_reset, exp_core_reset, loader_reset, exp_loader_reset,
  input  logic [63:0] core_mapper_flags, exp_core_flags,
  input  logic        has_save, exp_has_save, is_fds, exp_is_fds,
  input  logic [24:0] ch0_addr, exp_ch0_addr, ch2_addr, exp_ch2_addr,
  input  logic [7:0]  ch0_din, exp_ch0_din, ch2_din, exp_ch2_din,
  input  logic        ch0_wr, exp_ch0_wr, ch0_rd, exp_ch0_rd,
  input  logic        ch2_wr, exp_ch2_wr, ch2_rd, exp_ch2_rd,
  input  logic [7:0]  sd_buff_din, exp_sd_buff_din,
  output int          error_count,
  output int          check_count
);

  int errors = 0;
  int checks = 0;

  assign error_count = errors;
  assign check_count = checks;

  task automatic compare(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // inputs settle from the falling edge, so sample at the rising edge
  always @(posedge clk_ppu_21_47) begin
    if (!reset_nes) begin
      if (chk_joy) begin
        compare("joy1_data", 64'(joy1_data), 64'(exp_joy1));
        compare("joy2_data", 64'(joy2_data), 64'(exp_joy2));
      end
      if (chk_core_reset) compare("core_reset", 64'(core_reset), 64'(exp_core_reset));
      if (chk_loader_reset) compare("loader_reset", 64'(loader_reset), 64'(exp_loader_reset));
      if (chk_flags) begin
        compare("core_mapper_flags", core_mapper_flags, exp_core_flags);
        compare("has_save", 64'(has_save), 64'(exp_has_save));
        compare("is_fds", 64'(is_fds), 64'(exp_is_fds));
      end
      if (chk_mux) begin
        compare("ch0_addr", 64'(ch0_addr), 64'(exp_ch0_addr));
        compare("ch0_din", 64'(ch0_din), 64'(exp_ch0_din));
        compare("ch0_wr", 64'(ch0_wr), 64'(exp_ch0_wr));
        compare("ch0_rd", 64'(ch0_rd), 64'(exp_ch0_rd));
        compare("ch2_addr", 64'(ch2_addr), 64'(exp_ch2_addr));
        compare("ch2_din", 64'(ch2_din), 64'(exp_ch2_din));
        compare("ch2_wr", 64'(ch2_wr), 64'(exp_ch2_wr));
        compare("ch2_rd", 64'(ch2_rd), 64'(exp_ch2_rd));
        compare("sd_buff_din", 64'(sd_buff_din), 64'(exp_sd_buff_din));
      end
    end
  end

endmodule

//--- tb_nes_glue.sv
`timescale 1ns/100ps

module tb_nes_glue;

  localparam logic [1:0] kind_joypad = 2'd0;
  localparam logic [1:0] kind_download = 2'd1;
  localparam logic [1:0] kind_mux = 2'd2;
  localparam int max_rows = 16;

  typedef struct packed {
    logic [1:0]  kind;
    logic [31:0] buttons;
    logic        multitap;
    logic [63:0] flags;
    logic        loading;
    logic        save_sleep;
    logic        ch2_busy;
    logic        bram_en;
  } row_t;

  logic clk_ppu_21_47, reset_nes;
  logic multitap_enabled, joy_strobe;
  logic [1:0] joy_clock;
  logic [7:0] p1_buttons, p2_buttons, p3_buttons, p4_buttons;
  logic downloading, loader_busy, loader_done, loader_fail, hold_reset;
  logic [63:0] loader_flags;
  logic [24:0] loader_addr, ss_sdram_addr;
  logic [21:0] ppu_addr;
  logic [17:0] sd_buff_addr;
  logic [7:0] loader_data, ppu_dout, ss_sdram_wdata, sd_buff_dout, ch2_dout, eeprom_dout;
  logic loader_write, ppu_read, ppu_write, save_sleep, ss_sdram_wr, ss_sdram_rd;
  logic sd_buff_wr, sd_buff_rd, bram_en, ch2_busy;

  // dut outputs
  logic joy1_data, joy2_data, core_reset, loader_reset, has_save, is_fds;
  logic [63:0] core_mapper_flags;
  logic [24:0] ch0_addr, ch2_addr;
  logic [7:0] ch0_din, ch2_din, sd_buff_din;
  logic ch0_wr, ch0_rd, ch2_wr, ch2_rd;

  // check enables and expected values for the checker
  logic chk_joy, chk_core_reset, chk_loader_reset, chk_flags, chk_mux;
  logic exp_joy1, exp_joy2, exp_core_reset, exp_loader_reset, exp_has_save, exp_is_fds;
  logic [63:0] exp_core_flags;
  logic [24:0] exp_ch0_addr, exp_ch2_addr;
  logic [7:0] exp_ch0_din, exp_ch2_din;
  logic exp_ch0_wr, exp_ch0_rd, exp_ch2_wr, exp_ch2_rd;
  logic [7:0] exp_sd_buff_din;
  int error_count, check_count;

  row_t rows [max_rows];
  int n_rows = 0;
  int cycle_limit;
  int cycle_count = 0;
  logic [31:0] lcg_state;
  logic [63:0] latched_flags;

  nes_glue_top UUT (.*);

  nes_glue_checker u_checker (.*);

  initial begin
    clk_ppu_21_47 = 1'b0;
    forever #2 clk_ppu_21_47 = ~clk_ppu_21_47;
  end

  // run limit from the table length
  always @(posedge clk_ppu_21_47) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // bit idx of one port stream, pad then extra pad and signature, or ones
  function automatic logic stream_bit(input logic [7:0] pad, input logic [7:0] extra,
                                      input logic [7:0] sig, input logic mt, input int idx);
    logic [2:0] b;
    b = idx[2:0];
    if (idx < 8) return pad[b];
    if (idx >= 24) return 1'b0;
    if (!mt) return 1'b1;
    if (idx < 16) return extra[b];
    return sig[b];
  endfunction

  task automatic add_row(input logic [1:0] kind, input logic mt, input logic [63:0] flags,
                         input logic loading, input logic sleep, input logic busy,
                         input logic bram);
    rows[n_rows] = '{kind, lcg_next(), mt, flags, loading, sleep, busy, bram};
    if (kind == kind_joypad) cycle_limit += 56;
    else if (kind == kind_download) cycle_limit += 264;
    else cycle_limit += 2;
    n_rows++;
  endtask

  task automatic clear_checks();
    chk_joy = 1'b0;
    chk_core_reset = 1'b0;
    chk_loader_reset = 1'b0;
    chk_flags = 1'b0;
    chk_mux = 1'b0;
  endtask

  task automatic expect_latched_flags();
    exp_has_save = latched_flags[25];
    exp_is_fds = (latched_flags[7:0] == 8'h14);
  endtask

  task automatic run_joypad(input row_t row);
    @(negedge clk_ppu_21_47);
    clear_checks();
    {p4_buttons, p3_buttons, p2_buttons, p1_buttons} = row.buttons;
    multitap_enabled = row.multitap;
    joy_strobe = 1'b1;
    joy_clock = 2'b00;
    @(negedge clk_ppu_21_47);
    joy_strobe = 1'b0;
    chk_joy = 1'b1;
    // one pulse per bit, the last pass only reads the drained stream
    for (int p = 0; p <= 26; p++) begin
      exp_joy1 = stream_bit(p1_buttons, p3_buttons, 8'h08, row.multitap, p);
      exp_joy2 = stream_bit(p2_buttons, p4_buttons, 8'h04, row.multitap, p);
      joy_clock = (p < 26) ? 2'b11 : 2'b00;
      @(negedge clk_ppu_21_47);
      joy_clock = 2'b00;
      @(negedge clk_ppu_21_47);
    end
  endtask

  task automatic run_download(input row_t row);
    @(negedge clk_ppu_21_47);
    clear_checks();
    downloading = 1'b1;
    loader_busy = 1'b0;
    loader_flags = row.flags;
    chk_flags = 1'b1;
    exp_core_flags = '0;
    expect_latched_flags();
    // hold counter is loaded from here on, so the core stays in reset
    @(negedge clk_ppu_21_47);
    downloading = 1'b0;
    exp_core_flags = latched_flags;
    chk_core_reset = 1'b1;
    exp_core_reset = 1'b1;
    chk_loader_reset = 1'b1;
    exp_loader_reset = 1'b1;
    // short drop, the download restarts while the counter still runs
    @(negedge clk_ppu_21_47);
    downloading = 1'b1;
    exp_core_flags = '0;
    exp_loader_reset = 1'b0;
    @(negedge clk_ppu_21_47);
    exp_loader_reset = 1'b1;
    @(negedge clk_ppu_21_47);
    exp_loader_reset = 1'b0;
    loader_done = 1'b1;
    @(negedge clk_ppu_21_47);
    loader_done = 1'b0;
    latched_flags = row.flags;
    expect_latched_flags();
    @(negedge clk_ppu_21_47);
    downloading = 1'b0;
    exp_core_flags = row.flags;
    // cycle 0 is the first one after the download ends
    for (int c = 0; c <= 256; c++) begin
      exp_core_reset = (c < 255);
      exp_loader_reset = (c == 256);
      @(negedge clk_ppu_21_47);
    end
  endtask

  task automatic run_mux(input row_t row);
    logic [31:0] r;
    @(negedge clk_ppu_21_47);
    clear_checks();
    loader_busy = row.loading;
    save_sleep = row.save_sleep;
    ch2_busy = row.ch2_busy;
    bram_en = row.bram_en;
    r = lcg_next();
    loader_addr = r[31:7];
    loader_data = r[7:0];
    r = lcg_next();
    ppu_addr = r[31:10];
    ppu_dout = r[7:0];
    loader_write = r[8];
    ppu_write = r[9];
    r = lcg_next();
    ss_sdram_addr = r[31:7];
    ss_sdram_wdata = r[7:0];
    r = lcg_next();
    sd_buff_addr = r[31:14];
    sd_buff_dout = r[13:6];
    ch2_dout = r[7:0];
    eeprom_dout = ~r[7:0];
    ppu_read = 1'b1;
    sd_buff_wr = 1'b1;
    sd_buff_rd = 1'b1;
    ss_sdram_wr = 1'b1;
    ss_sdram_rd = 1'b0;
    exp_ch0_addr = row.loading ? loader_addr : {3'b000, ppu_addr};
    exp_ch0_din = row.loading ? loader_data : ppu_dout;
    exp_ch0_wr = loader_write || ppu_write;
    exp_ch0_rd = !row.loading;
    exp_ch2_addr = row.save_sleep ? ss_sdram_addr : {7'b0001111, sd_buff_addr};
    exp_ch2_din = row.save_sleep ? ss_sdram_wdata : sd_buff_dout;
    exp_ch2_wr = row.save_sleep ? 1'b1 : !row.ch2_busy;
    exp_ch2_rd = row.save_sleep ? 1'b0 : !row.ch2_busy;
    exp_sd_buff_din = row.bram_en ? eeprom_dout : ch2_dout;
    chk_mux = 1'b1;
    @(negedge clk_ppu_21_47);
    chk_mux = 1'b0;
    loader_busy = 1'b0;
  endtask

  initial begin
    reset_nes = 1'b1;
    {multitap_enabled, joy_strobe, joy_clock} = '0;
    {p1_buttons, p2_buttons, p3_buttons, p4_buttons} = '0;
    {downloading, loader_busy, loader_done, loader_fail, hold_reset} = '0;
    loader_flags = '0;
    {loader_addr, ss_sdram_addr, ppu_addr, sd_buff_addr} = '0;
    {loader_data, ppu_dout, ss_sdram_wdata, sd_buff_dout, ch2_dout, eeprom_dout} = '0;
    {loader_write, ppu_read, ppu_write, save_sleep, ss_sdram_wr, ss_sdram_rd} = '0;
    {sd_buff_wr, sd_buff_rd, bram_en, ch2_busy} = '0;
    clear_checks();
    {exp_joy1, exp_joy2, exp_core_reset, exp_loader_reset, exp_has_save, exp_is_fds} = '0;
    {exp_core_flags, exp_ch0_addr, exp_ch2_addr, exp_ch0_rd, exp_ch2_wr} = '0;
    {exp_ch0_din, exp_ch2_din, exp_ch0_wr, exp_ch2_rd} = '0;
    exp_sd_buff_din = '0;
    latched_flags = '0;
    lcg_state = 32'h0e52_fe80;
    cycle_limit = 0;
    // kind, multitap, flags, loading, save_sleep, ch2_busy, bram_en
    add_row(kind_download, 1'b0, 64'h0000_0000_0200_0014, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(kind_joypad, 1'b0, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(kind_joypad, 1'b1, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(kind_mux, 1'b0, 64'h0, 1'b1, 1'b0, 1'b0, 1'b1);
    add_row(kind_mux, 1'b0, 64'h0, 1'b0, 1'b0, 1'b1, 1'b0);
    add_row(kind_download, 1'b0, 64'h5a00_0000_0000_0004, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(kind_mux, 1'b0, 64'h0, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row(kind_joypad, 1'b1, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0);
    cycle_limit += 500;
    repeat (2) @(negedge clk_ppu_21_47);
    reset_nes = 1'b0;
    // no download yet, core held and streams empty
    chk_core_reset = 1'b1;
    exp_core_reset = 1'b1;
    chk_joy = 1'b1;
    chk_flags = 1'b1;
    repeat (4) @(negedge clk_ppu_21_47);
    for (int i = 0; i < n_rows; i++) begin
      if (rows[i].kind == kind_joypad) run_joypad(rows[i]);
      else if (rows[i].kind == kind_download) run_download(rows[i]);
      else run_mux(rows[i]);
    end
    @(negedge clk_ppu_21_47);
    clear_checks();
    @(negedge clk_ppu_21_47);
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- flist.f
nes_glue_pkg.sv
joypad_serializer.sv
load_control.sv
sdram_channel_mux.sv
nes_glue_top.sv
nes_glue_checker.sv
tb_nes_glue.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with verilator, runs it and scans the log

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --top-module tb_nes_glue \
  -f flist.f -o tb_nes_glue > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$build_log"
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_nes_glue > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$sim_log"; then
  exit 1
fi
if ! grep -q "Test passed" "$sim_log"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
